/* flist.f */
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu_top.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

/* hdl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } imm_kind_e;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        branch;
        logic        jump;
        logic        alu_src;    // second operand is the immediate
        alu_op_e     alu_op;
        result_src_e result_src;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic                  mem_write;
        result_src_e           result_src;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

/* hdl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
)(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          imem_we_i,
    input  wire logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  wire logic [cpu_pkg::XLEN-1:0]      imem_data_i,
    output cpu_pkg::wb_t                       wb_o,
    output logic      [cpu_pkg::XLEN-1:0]      a0_o
);
    cpu_pkg::if_id_t                  if_id;
    cpu_pkg::id_ex_t                  id_ex;
    cpu_pkg::ex_mem_t                 ex_mem;
    logic [cpu_pkg::REG_ADDR_W-1:0]   rs1_addr;
    logic [cpu_pkg::REG_ADDR_W-1:0]   rs2_addr;
    logic [cpu_pkg::XLEN-1:0]         rs1_data;
    logic [cpu_pkg::XLEN-1:0]         rs2_data;
    logic                             redirect;
    logic [cpu_pkg::XLEN-1:0]         target;

    fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .imem_we_i   (imem_we_i),
        .imem_addr_i (imem_addr_i),
        .imem_data_i (imem_data_i),
        .redirect_i  (redirect),
        .target_i    (target),
        .if_id_o     (if_id)
    );

    decode_stage i_decode (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .flush_i    (redirect),      // drops the instruction behind a taken jump
        .if_id_i    (if_id),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .id_ex_o    (id_ex)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_i       (wb_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .a0_o       (a0_o)
    );

    execute_stage i_execute (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .id_ex_i    (id_ex),
        .fwd_i      (wb_o),
        .redirect_o (redirect),
        .target_o   (target),
        .ex_mem_o   (ex_mem)
    );

    mem_wb_stage #(.DMEM_WORDS(DMEM_WORDS)) i_mem_wb (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ex_mem_i (ex_mem),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                             clk_i,
    input  wire logic                             rst_i,
    input  wire logic                             flush_i,
    input  cpu_pkg::if_id_t                       if_id_i,
    input  wire logic [cpu_pkg::XLEN-1:0]         rs1_data_i,
    input  wire logic [cpu_pkg::XLEN-1:0]         rs2_data_i,
    output logic      [cpu_pkg::REG_ADDR_W-1:0]   rs1_addr_o,
    output logic      [cpu_pkg::REG_ADDR_W-1:0]   rs2_addr_o,
    output cpu_pkg::id_ex_t                       id_ex_o
);
    logic [cpu_pkg::XLEN-1:0] instr;
    logic [2:0]               funct3;
    cpu_pkg::ctrl_t           ctrl;
    cpu_pkg::imm_kind_e       imm_kind;
    logic                     known;     // opcode belongs to the subset
    logic [cpu_pkg::XLEN-1:0] imm;

    assign instr      = if_id_i.instr;
    assign funct3     = instr[14:12];
    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];

    always_comb begin
        ctrl     = '0;
        imm_kind = cpu_pkg::IMM_I;
        known    = 1'b1;
        case (cpu_pkg::opcode_e'(instr[6:0]))
            cpu_pkg::OP_REG: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = instr[30] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                    3'b111:  ctrl.alu_op = cpu_pkg::ALU_AND;
                    3'b110:  ctrl.alu_op = cpu_pkg::ALU_OR;
                    3'b010:  ctrl.alu_op = cpu_pkg::ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            cpu_pkg::OP_IMM: begin      // addi only
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                known          = (funct3 == 3'b000);
            end
            cpu_pkg::OP_LOAD: begin     // lw
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = cpu_pkg::RES_MEM;
                known           = (funct3 == 3'b010);
            end
            cpu_pkg::OP_STORE: begin    // sw
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm_kind       = cpu_pkg::IMM_S;
                known          = (funct3 == 3'b010);
            end
            cpu_pkg::OP_BRANCH: begin   // beq
                ctrl.branch = 1'b1;
                ctrl.alu_op = cpu_pkg::ALU_SUB;
                imm_kind    = cpu_pkg::IMM_B;
                known       = (funct3 == 3'b000);
            end
            cpu_pkg::OP_JAL: begin
                ctrl.jump       = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = cpu_pkg::RES_PC4;
                imm_kind        = cpu_pkg::IMM_J;
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            ctrl = '0;                  // unsupported word does nothing
        end
    end

    // sign extension by format
    always_comb begin
        case (imm_kind)
            cpu_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            cpu_pkg::IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7],
                                   instr[30:25], instr[11:8], 1'b0};
            cpu_pkg::IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                   instr[20], instr[30:21], 1'b0};
            default:        imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // decode/execute register
    always_ff @(posedge clk_i) begin
        id_ex_o.ctrl     <= ctrl;
        id_ex_o.pc       <= if_id_i.pc;
        id_ex_o.rs1      <= rs1_addr_o;
        id_ex_o.rs2      <= rs2_addr_o;
        id_ex_o.rd       <= instr[11:7];
        id_ex_o.rs1_data <= rs1_data_i;
        id_ex_o.rs2_data <= rs2_data_i;
        id_ex_o.imm      <= imm;
        if (rst_i || flush_i) begin
            id_ex_o.valid <= 1'b0;
        end else begin
            id_ex_o.valid <= if_id_i.valid && known;
        end
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  cpu_pkg::id_ex_t               id_ex_i,
    input  cpu_pkg::wb_t                  fwd_i,        // result of the memory stage
    output logic                          redirect_o,
    output logic [cpu_pkg::XLEN-1:0]      target_o,
    output cpu_pkg::ex_mem_t              ex_mem_o
);
    logic [cpu_pkg::XLEN-1:0] op_a;
    logic [cpu_pkg::XLEN-1:0] op_b_reg;     // forwarded rs2 and the store data
    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [cpu_pkg::XLEN-1:0] alu_result;
    logic                     take_branch;

    // older instruction in memory wins over register file data
    assign op_a = (fwd_i.valid && fwd_i.rd != '0 && fwd_i.rd == id_ex_i.rs1)
                  ? fwd_i.data : id_ex_i.rs1_data;
    assign op_b_reg = (fwd_i.valid && fwd_i.rd != '0 && fwd_i.rd == id_ex_i.rs2)
                      ? fwd_i.data : id_ex_i.rs2_data;
    assign op_b = id_ex_i.ctrl.alu_src ? id_ex_i.imm : op_b_reg;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            cpu_pkg::ALU_SUB: alu_result = op_a - op_b;
            cpu_pkg::ALU_AND: alu_result = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | op_b;
            cpu_pkg::ALU_SLT: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default:          alu_result = op_a + op_b;
        endcase
    end

    assign take_branch = id_ex_i.ctrl.branch && (alu_result == '0);  // beq via sub
    assign redirect_o  = id_ex_i.valid && (id_ex_i.ctrl.jump || take_branch);
    assign target_o    = id_ex_i.pc + id_ex_i.imm;

    // execute/memory register
    always_ff @(posedge clk_i) begin
        ex_mem_o.result_src <= id_ex_i.ctrl.result_src;
        ex_mem_o.rd         <= id_ex_i.rd;
        ex_mem_o.alu_result <= alu_result;
        ex_mem_o.store_data <= op_b_reg;
        ex_mem_o.pc_plus4   <= id_ex_i.pc + 32'd4;
        if (rst_i) begin
            ex_mem_o.valid     <= 1'b0;
            ex_mem_o.reg_write <= 1'b0;
            ex_mem_o.mem_write <= 1'b0;
        end else begin
            ex_mem_o.valid     <= id_ex_i.valid;
            ex_mem_o.reg_write <= id_ex_i.valid && id_ex_i.ctrl.reg_write;
            ex_mem_o.mem_write <= id_ex_i.valid && id_ex_i.ctrl.mem_write;
        end
    end

    // a redirect needs a real instruction, and decode flush leaves a bubble behind it
    a_redirect_valid : assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_o |-> id_ex_i.valid ##1 !id_ex_i.valid)
        else $error("redirect without a valid instruction or without a flush");

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter int IMEM_WORDS = 256
)(
    input  wire logic                          clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          imem_we_i,
    input  wire logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,   // word index
    input  wire logic [cpu_pkg::XLEN-1:0]      imem_data_i,
    input  wire logic                          redirect_i,
    input  wire logic [cpu_pkg::XLEN-1:0]      target_i,
    output cpu_pkg::if_id_t                    if_id_o
);
    localparam int IDX_W = $clog2(IMEM_WORDS);

    logic [cpu_pkg::XLEN-1:0] pc;
    logic [cpu_pkg::XLEN-1:0] instr;
    logic [cpu_pkg::XLEN-1:0] imem [IMEM_WORDS];

    // load port for use while the core sits in reset
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    assign instr = imem[pc[IDX_W+1:2]]; // word aligned fetch

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc <= '0;
        end else if (redirect_i) begin
            pc <= target_i;             // taken branch or jal
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk_i) begin
        if_id_o.pc    <= pc;
        if_id_o.instr <= instr;
        if (rst_i || redirect_i) begin
            if_id_o.valid <= 1'b0;      // wrong-path word becomes a bubble
        end else begin
            if_id_o.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
    parameter int DMEM_WORDS = 256
)(
    input  wire logic          clk_i,
    input  wire logic          rst_i,
    input  cpu_pkg::ex_mem_t   ex_mem_i,
    output cpu_pkg::wb_t       wb_o
);
    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [cpu_pkg::XLEN-1:0] dmem [DMEM_WORDS];
    logic [IDX_W-1:0]         dmem_idx;
    logic [cpu_pkg::XLEN-1:0] read_data;

    assign dmem_idx = ex_mem_i.alu_result[IDX_W+1:2];   // word address

    // store lands at the edge closing the memory stage
    always_ff @(posedge clk_i) begin
        if (ex_mem_i.valid && ex_mem_i.mem_write) begin
            dmem[dmem_idx] <= ex_mem_i.store_data;
        end
    end

    assign read_data = dmem[dmem_idx];

    always_comb begin
        case (ex_mem_i.result_src)
            cpu_pkg::RES_MEM: wb_o.data = read_data;
            cpu_pkg::RES_PC4: wb_o.data = ex_mem_i.pc_plus4;   // jal link
            default:          wb_o.data = ex_mem_i.alu_result;
        endcase
    end

    assign wb_o.rd    = ex_mem_i.rd;
    assign wb_o.valid = ex_mem_i.valid && ex_mem_i.reg_write && ex_mem_i.rd != '0;

    // decode never sets both for one instruction
    a_write_exclusive : assert property (@(posedge clk_i) disable iff (rst_i)
        ex_mem_i.valid |-> !(ex_mem_i.mem_write && ex_mem_i.reg_write))
        else $error("store and register write on the same instruction");

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                           clk_i,
    input  wire logic                           rst_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  cpu_pkg::wb_t                        wb_i,
    output logic      [cpu_pkg::XLEN-1:0]       rs1_data_o,
    output logic      [cpu_pkg::XLEN-1:0]       rs2_data_o,
    output logic      [cpu_pkg::XLEN-1:0]       a0_o
);
    logic [cpu_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through keeps decode free of a stall
    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end else if (wb_i.valid && wb_i.rd == rs1_addr_i) begin
            rs1_data_o = wb_i.data;
        end else begin
            rs1_data_o = regs[rs1_addr_i];
        end
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else if (wb_i.valid && wb_i.rd == rs2_addr_i) begin
            rs2_data_o = wb_i.data;
        end else begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

    assign a0_o = regs[10];     // x10

    // writeback side filters x0, so x0 is never stored
    a_no_x0_write : assert property (@(posedge clk_i) disable iff (rst_i)
        wb_i.valid |-> wb_i.rd != '0)
        else $error("register file saw a write to x0");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcpu_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0

/* verification/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker #(
    parameter int MAX_W = 32
)(
    input  wire logic         clk_i,
    input  wire logic         rst_i,
    input  cpu_pkg::wb_t      wb_i,
    input  wire logic [31:0]  a0_i,
    input  wire logic [4:0]   exp_rd_i [MAX_W],
    input  wire logic [31:0]  exp_data_i [MAX_W],
    input  wire logic [127:0] exp_name_i [MAX_W],
    input  wire logic [31:0]  exp_count_i,
    input  wire logic [31:0]  exp_a0_i,
    output logic              done_o,
    output logic [31:0]       mismatch_count_o,
    output logic [31:0]       failure_count_o
);
    localparam int RESET_TIMEOUT = 100;
    localparam int WB_TIMEOUT    = 100;    // cycles allowed between two writebacks
    localparam int QUIET_CYCLES  = 50;

    int seen;

    // packed name from the trace without its leading null bytes
    function automatic string name_text(input logic [127:0] packed_name);
        string s;
        s = "";
        for (int b = 15; b >= 0; b--) begin
            if (packed_name[b*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, packed_name[b*8 +: 8]);
            end
        end
        return s;
    endfunction

    task automatic wait_reset_release(output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk_i);           // reset is driven by then
        while (rst_i !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        ok = (rst_i === 1'b0);
    endtask

    // outputs sampled at the falling edge in mid cycle
    task automatic wait_writeback(output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!wb_i.valid && cycles < WB_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        ok = wb_i.valid;
    endtask

    task automatic compare_writeback(input int idx);
        if (wb_i.rd !== exp_rd_i[idx] || wb_i.data !== exp_data_i[idx]) begin
            $display("Mismatch in %s: expected x%0d = %08h, actual x%0d = %08h",
                     name_text(exp_name_i[idx]), exp_rd_i[idx], exp_data_i[idx],
                     wb_i.rd, wb_i.data);
            mismatch_count_o++;
        end
    endtask

    // self-loop writes x0 only, so the strobe must stay low
    task automatic check_quiet();
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk_i);
            if (wb_i.valid) begin
                $display("unexpected writeback to x%0d with %08h after the last expected one",
                         wb_i.rd, wb_i.data);
                failure_count_o++;
            end
        end
    endtask

    initial begin
        logic ok;
        done_o           = 1'b0;
        mismatch_count_o = '0;
        failure_count_o  = '0;
        seen             = 0;
        wait_reset_release(ok);
        if (!ok) begin
            $display("reset was never released");
            failure_count_o++;
        end else begin
            for (int i = 0; i < int'(exp_count_i); i++) begin
                wait_writeback(ok);
                if (!ok) begin
                    $display("writeback %0d (%s) did not appear within %0d cycles",
                             i, name_text(exp_name_i[i]), WB_TIMEOUT);
                    failure_count_o++;
                    break;
                end
                compare_writeback(i);
                seen++;
            end
            check_quiet();
            if (a0_i !== exp_a0_i) begin
                $display("Mismatch in final_a0: expected %08h, actual %08h", exp_a0_i, a0_i);
                mismatch_count_o++;
            end
        end
        $display("checker: %0d of %0d writebacks seen, %0d mismatches, %0d other errors",
                 seen, exp_count_i, mismatch_count_o, failure_count_o);
        done_o = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 256;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_P        = 64;
    localparam int MAX_W        = 32;
    localparam int DONE_TIMEOUT = 4000;

    logic                          clk;
    logic                          rst;
    logic                          imem_we;
    logic [$clog2(IMEM_WORDS)-1:0] imem_addr;
    logic [31:0]                   imem_data;
    cpu_pkg::wb_t                  wb;
    logic [31:0]                   a0;

    logic [31:0]  p_addr [MAX_P];
    logic [31:0]  p_word [MAX_P];
    logic [4:0]   exp_rd [MAX_W];
    logic [31:0]  exp_data [MAX_W];
    logic [127:0] exp_name [MAX_W];
    logic [31:0]  exp_a0;
    int           p_count;
    int           exp_count;
    int           setup_errors;
    logic         check_done;
    logic [31:0]  mismatch_count;
    logic [31:0]  failure_count;

    always #20 clk = ~clk;     // 40 ns period

    cpu_top #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) i_dut (
        .clk_i       (clk),
        .rst_i       (rst),
        .imem_we_i   (imem_we),
        .imem_addr_i (imem_addr),
        .imem_data_i (imem_data),
        .wb_o        (wb),
        .a0_o        (a0)
    );

    cpu_checker #(.MAX_W(MAX_W)) i_checker (
        .clk_i            (clk),
        .rst_i            (rst),
        .wb_i             (wb),
        .a0_i             (a0),
        .exp_rd_i         (exp_rd),
        .exp_data_i       (exp_data),
        .exp_name_i       (exp_name),
        .exp_count_i      (exp_count),
        .exp_a0_i         (exp_a0),
        .done_o           (check_done),
        .mismatch_count_o (mismatch_count),
        .failure_count_o  (failure_count)
    );

    task automatic read_trace();
        int           fd;
        int           n;
        string        line;
        logic [63:0]  key;
        logic [127:0] name;
        logic [31:0]  val_a;
        logic [31:0]  val_b;
        fd = $fopen("verification/program_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/program_trace.txt");
            setup_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                key  = '0;
                n    = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", key);
                end
                if (n < 1 || key == "#") begin
                    n = 0;                          // blank or comment line
                end else if (key == "P" && p_count < MAX_P) begin
                    n = $sscanf(line, "%s %h %h", key, val_a, val_b);
                    p_addr[p_count] = val_a;
                    p_word[p_count] = val_b;
                    p_count++;
                end else if (key == "W" && exp_count < MAX_W) begin
                    n = $sscanf(line, "%s %s %h %h", key, name, val_a, val_b);
                    exp_name[exp_count] = name;
                    exp_rd[exp_count]   = val_a[4:0];
                    exp_data[exp_count] = val_b;
                    exp_count++;
                end else if (key == "A") begin
                    n = $sscanf(line, "%s %h", key, exp_a0);
                end else begin
                    $display("trace line not understood or too many entries: %s", line);
                    setup_errors++;
                end
            end
            $fclose(fd);
        end
        if (p_count == 0 || p_count > RESET_CYCLES || exp_count == 0) begin
            $display("trace holds %0d program words and %0d writebacks, program must fit in %0d",
                     p_count, exp_count, RESET_CYCLES);
            setup_errors++;
        end
    endtask

    // one program word per reset cycle and reset drops after the last load edge
    task automatic load_program();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            if (i < p_count) begin
                imem_we   = 1'b1;
                imem_addr = p_addr[i][$clog2(IMEM_WORDS)-1:0];
                imem_data = p_word[i];
            end else begin
                imem_we = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        rst     = 1'b0;
    endtask

    initial begin
        int cycles;
        clk          = 1'b0;
        rst          = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        exp_a0       = '0;
        p_count      = 0;
        exp_count    = 0;
        setup_errors = 0;
        cycles       = 0;
        read_trace();
        if (setup_errors != 0) begin
            $display("trace file unusable, %0d setup errors", setup_errors);
            $display("Simulation failed");
            $finish;
        end else begin
            load_program();
            while (!check_done && cycles < DONE_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (!check_done) begin
                $display("timeout after %0d cycles with %0d mismatches and %0d other errors",
                         DONE_TIMEOUT, mismatch_count, failure_count);
                $display("Simulation failed");
            end else if (mismatch_count == 0 && failure_count == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/program_trace.txt */
# P <imem word index> <instruction>  |  W <test> <rd> <data>  |  A <final a0>
# all numbers hex, W lines in retirement order
P 00 00700093  # addi x1, x0, 7
P 01 40100133  # sub  x2, x0, x1
P 02 001171b3  # and  x3, x2, x1
P 03 0021e233  # or   x4, x3, x2
P 04 003222b3  # slt  x5, x4, x3
P 05 00402623  # sw   x4, 12(x0)
P 06 00c02303  # lw   x6, 12(x0)
P 07 00530533  # add  x10, x6, x5
P 08 00028463  # beq  x5, x0, +8   not taken
P 09 00a50663  # beq  x10, x10, +12  taken
P 0a 06300513  # addi x10, x0, 99  skipped
P 0b 04d00513  # addi x10, x0, 77  skipped
P 0c 00c005ef  # jal  x11, +12
P 0d 03700513  # addi x10, x0, 55  skipped
P 0e 04200593  # addi x11, x0, 66  skipped
P 0f 0000006f  # jal  x0, 0  self-loop
W addi         01 00000007
W sub_fwd      02 fffffff9
W and_fwd      03 00000001
W or_fwd       04 fffffff9
W slt_neg      05 00000001
W lw_after_sw  06 fffffff9
W add_load_use 0a fffffffa
W jal_link     0b 00000034
A fffffffa
